//--- hdl/axil2simp.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module axil2simp import uart_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    awvalid_i,
	input  logic [`UART_ADDR_W-1:0] awaddr_i,
	output logic                    awready_o,
	input  logic                    wvalid_i,
	input  logic [31:0]             wdata_i,
	input  logic [3:0]              wstrb_i,
	output logic                    wready_o,
	output logic                    bvalid_o,
	output logic [1:0]              bresp_o,
	input  logic                    bready_i,
	input  logic                    arvalid_i,
	input  logic [`UART_ADDR_W-1:0] araddr_i,
	output logic                    arready_o,
	output logic                    rvalid_o,
	output logic [31:0]             rdata_o,
	output logic [1:0]              rresp_o,
	input  logic                    rready_i,
	simp_bus_if.master              bus
);

	axil_state_e             state;
	logic                    bus_valid;
	logic                    aw_take;
	logic                    ar_take;
	logic [`UART_ADDR_W-1:0] addr_q;
	logic [31:0]             wdata_q;
	logic [3:0]              be_q;
	logic [31:0]             rdata_q;
	axi_resp_e               resp_q;

	// write pair wins over a read arriving in the same cycle
	assign aw_take = (state == IDLE) && awvalid_i && wvalid_i;
	assign ar_take = (state == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

	assign awready_o = aw_take;
	assign wready_o  = aw_take;
	assign arready_o = ar_take;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= IDLE;
			bus_valid <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (aw_take) begin
						state <= WR_BUS;
					end else if (ar_take) begin
						state <= RD_BUS;
					end
				end
				WR_BUS, RD_BUS: begin
					if (bus.done) begin
						bus_valid <= 1'b0;
						if (state == WR_BUS) begin
							state <= WR_RESP;
						end else begin
							state <= RD_RESP;
						end
					end else begin
						bus_valid <= 1'b1;
					end
				end
				WR_RESP: begin
					if (bready_i) begin
						state <= IDLE;
					end
				end
				RD_RESP: begin
					if (rready_i) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_take) begin
			addr_q  <= awaddr_i;
			wdata_q <= wdata_i;
			be_q    <= wstrb_i;
		end else if (ar_take) begin
			addr_q <= araddr_i;
		end
		if (bus.valid && bus.done) begin
			rdata_q <= bus.rdata;
			if (bus.err) begin
				resp_q <= SLVERR;
			end else begin
				resp_q <= OKAY;
			end
		end
	end

	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.be    = be_q;
	assign bus.wr    = (state == WR_BUS);
	assign bus.rd    = (state == RD_BUS);
	assign bus.valid = bus_valid;

	assign bvalid_o = (state == WR_RESP);
	assign bresp_o  = resp_q;
	assign rvalid_o = (state == RD_RESP);
	assign rdata_o  = rdata_q;
	assign rresp_o  = resp_q;

	a_one_resp: assert property (@(posedge clk) disable iff (rst) !(bvalid_o && rvalid_o));

	// request must be held until the register block answers
	a_valid_hold: assert property (@(posedge clk) disable iff (rst)
		bus.valid && !bus.done |=> bus.valid);

endmodule : axil2simp

//--- hdl/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
	parameter int ADDR_W = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            push_i,
	input  logic [7:0]      din_i,
	input  logic            pop_i,
	output logic [7:0]      dout_o,
	output logic            empty_o,
	output logic            full_o,
	output logic [ADDR_W:0] count_o
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [7:0]        mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0]   count;
	logic              do_push;
	logic              do_pop;

	assign empty_o = (count == '0);
	assign full_o  = (count == (ADDR_W+1)'(DEPTH));
	assign count_o = count;
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and read register
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din_i;
		end
		if (do_pop) begin
			dout_o <= mem[rd_ptr];
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (rst)
		count <= (ADDR_W+1)'(DEPTH));

endmodule : byte_fifo

//--- hdl/simp_bus_if.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

interface simp_bus_if;

	logic [`UART_ADDR_W-1:0] addr;
	logic [31:0]             wdata;
	logic [3:0]              be;
	logic                    wr;
	logic                    rd;
	logic                    valid;

	// rdata and err only count while done is high
	logic [31:0]             rdata;
	logic                    done;
	logic                    err;

	modport master (output addr, wdata, be, wr, rd, valid, input rdata, done, err);

	modport slave (input addr, wdata, be, wr, rd, valid, output rdata, done, err);

endinterface : simp_bus_if

//--- hdl/uart_axil.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_axil (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    awvalid_i,
	input  logic [`UART_ADDR_W-1:0] awaddr_i,
	output logic                    awready_o,
	input  logic                    wvalid_i,
	input  logic [31:0]             wdata_i,
	input  logic [3:0]              wstrb_i,
	output logic                    wready_o,
	output logic                    bvalid_o,
	output logic [1:0]              bresp_o,
	input  logic                    bready_i,
	input  logic                    arvalid_i,
	input  logic [`UART_ADDR_W-1:0] araddr_i,
	output logic                    arready_o,
	output logic                    rvalid_o,
	output logic [31:0]             rdata_o,
	output logic [1:0]              rresp_o,
	input  logic                    rready_i,
	input  logic                    uart_rx_i,
	output logic                    uart_tx_o,
	input  logic                    uart_cts_i,
	output logic                    uart_rts_o
);

	logic                      tx_push;
	logic [7:0]                tx_din;
	logic                      tx_pop;
	logic [7:0]                tx_dout;
	logic                      tx_empty;
	logic                      tx_full;
	logic                      tx_busy;
	logic                      rx_push;
	logic [7:0]                rx_din;
	logic                      rx_pop;
	logic [7:0]                rx_dout;
	logic                      rx_empty;
	logic                      rx_full;
	logic [`UART_RX_FIFO_AW:0] rx_count;

	simp_bus_if bus ();

	axil2simp u_bridge (
		.clk       (clk),
		.rst       (rst),
		.awvalid_i (awvalid_i),
		.awaddr_i  (awaddr_i),
		.awready_o (awready_o),
		.wvalid_i  (wvalid_i),
		.wdata_i   (wdata_i),
		.wstrb_i   (wstrb_i),
		.wready_o  (wready_o),
		.bvalid_o  (bvalid_o),
		.bresp_o   (bresp_o),
		.bready_i  (bready_i),
		.arvalid_i (arvalid_i),
		.araddr_i  (araddr_i),
		.arready_o (arready_o),
		.rvalid_o  (rvalid_o),
		.rdata_o   (rdata_o),
		.rresp_o   (rresp_o),
		.rready_i  (rready_i),
		.bus       (bus.master)
	);

	uart_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.bus        (bus.slave),
		.tx_push_o  (tx_push),
		.tx_byte_o  (tx_din),
		.tx_full_i  (tx_full),
		.rx_pop_o   (rx_pop),
		.rx_byte_i  (rx_dout),
		.rx_empty_i (rx_empty),
		.rx_count_i (rx_count),
		.tx_busy_i  (tx_busy)
	);

	byte_fifo #(.ADDR_W(`UART_TX_FIFO_AW)) u_tx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (tx_push),
		.din_i   (tx_din),
		.pop_i   (tx_pop),
		.dout_o  (tx_dout),
		.empty_o (tx_empty),
		.full_o  (tx_full),
		.count_o ()
	);

	byte_fifo #(.ADDR_W(`UART_RX_FIFO_AW)) u_rx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rx_push),
		.din_i   (rx_din),
		.pop_i   (rx_pop),
		.dout_o  (rx_dout),
		.empty_o (rx_empty),
		.full_o  (rx_full),
		.count_o (rx_count)
	);

	uart_tx_serializer u_tx (
		.clk     (clk),
		.rst     (rst),
		.empty_i (tx_empty),
		.byte_i  (tx_dout),
		.pop_o   (tx_pop),
		.cts_i   (uart_cts_i),
		.busy_o  (tx_busy),
		.txd_o   (uart_tx_o)
	);

	uart_rx_deserializer u_rx (
		.clk          (clk),
		.rst          (rst),
		.rxd_i        (uart_rx_i),
		.byte_valid_o (rx_push),
		.byte_o       (rx_din)
	);

	// ask the far end to hold off while nothing more fits
	assign uart_rts_o = rx_full;

endmodule : uart_axil

//--- hdl/uart_baud_timer.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_baud_timer (
	input  logic clk,
	input  logic rst,
	input  logic run_i,
	output logic mid_o,
	output logic end_o
);

	localparam int CPB   = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	logic [CNT_W-1:0] cnt;
	logic             last;

	assign last = (cnt == CNT_W'(CPB - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (!run_i) begin
			cnt <= '0;
		end else if (last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// pulses only while running
	assign mid_o = run_i && (cnt == CNT_W'(CPB / 2 - 1));
	assign end_o = run_i && last;

endmodule : uart_baud_timer

//--- hdl/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

`define UART_CLK_FREQ     32'd10_000_000
`define UART_BAUD         32'd1_000_000
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD)

// fifo depth is 2**AW
`define UART_TX_FIFO_AW   4
`define UART_RX_FIFO_AW   4

// register map in byte addresses
`define UART_ADDR_W       4
`define UART_DATA_ADDR    4'd0
`define UART_RX_NUM_ADDR  4'd4
`define UART_STATUS_ADDR  4'd8

`endif

//--- hdl/uart_pkg.sv
package uart_pkg;

	typedef enum logic [2:0] {
		IDLE,
		WR_BUS,
		WR_RESP,
		RD_BUS,
		RD_RESP
	} axil_state_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_TX_PUSH,
		OP_RX_POP,
		OP_RX_COUNT,
		OP_STATUS,
		OP_BAD
	} reg_op_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage : uart_pkg

//--- hdl/uart_regs.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_regs import uart_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	simp_bus_if.slave                  bus,
	output logic                       tx_push_o,
	output logic [7:0]                 tx_byte_o,
	input  logic                       tx_full_i,
	output logic                       rx_pop_o,
	input  logic [7:0]                 rx_byte_i,
	input  logic                       rx_empty_i,
	input  logic [`UART_RX_FIFO_AW:0]  rx_count_i,
	input  logic                       tx_busy_i
);

	reg_op_e op_d;
	reg_op_e op_q;
	logic    rx_took_q;

	always_comb begin
		op_d = OP_BAD;
		if (bus.wr && bus.addr == `UART_DATA_ADDR) begin
			op_d = OP_TX_PUSH;
		end else if (bus.rd) begin
			unique case (bus.addr)
				`UART_DATA_ADDR:   op_d = OP_RX_POP;
				`UART_RX_NUM_ADDR: op_d = OP_RX_COUNT;
				`UART_STATUS_ADDR: op_d = OP_STATUS;
				default:           op_d = OP_BAD;
			endcase
		end
	end

	// pop while registering the op, so the byte is ready in the done cycle
	assign rx_pop_o = bus.valid && (op_q == OP_NONE) && (op_d == OP_RX_POP) && !rx_empty_i;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_q      <= OP_NONE;
			rx_took_q <= 1'b0;
		end else begin
			rx_took_q <= rx_pop_o;
			if (op_q != OP_NONE) begin
				op_q <= OP_NONE;
			end else if (bus.valid) begin
				op_q <= op_d;
			end
		end
	end

	assign bus.done = (op_q != OP_NONE);

	// data only travels in byte lane 0
	assign tx_push_o = (op_q == OP_TX_PUSH) && bus.be[0] && !tx_full_i;
	assign tx_byte_o = bus.wdata[7:0];

	assign bus.err = (op_q == OP_BAD) || ((op_q == OP_TX_PUSH) && tx_full_i);

	always_comb begin
		case (op_q)
			OP_RX_POP:   bus.rdata = rx_took_q ? {24'd0, rx_byte_i} : 32'd0;
			OP_RX_COUNT: bus.rdata = {{(31 - `UART_RX_FIFO_AW){1'b0}}, rx_count_i};
			OP_STATUS:   bus.rdata = {29'd0, tx_busy_i, rx_empty_i, tx_full_i};
			default:     bus.rdata = 32'd0;
		endcase
	end

	// tx fifo only fills through a push from this block
	a_full_after_push: assert property (@(posedge clk) disable iff (rst)
		$rose(tx_full_i) |-> $past(tx_push_o));

	// decoded op must still match the request it answers
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		bus.done |-> bus.valid && $stable(bus.addr) && $stable(bus.wr));

endmodule : uart_regs

//--- hdl/uart_rx_deserializer.sv
`timescale 1ns/10ps

module uart_rx_deserializer import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       rxd_i,
	output logic       byte_valid_o,
	output logic [7:0] byte_o
);

	rx_state_e  state;
	logic       rxd_s1;
	logic       rxd_s2;
	logic       rxd_d;
	logic       fall;
	logic       bit_mid;
	logic [2:0] bit_cnt;
	logic [7:0] shift_q;

	uart_baud_timer u_baud (
		.clk   (clk),
		.rst   (rst),
		.run_i (state != RX_IDLE),
		.mid_o (bit_mid),
		.end_o ()
	);

	// two-flop synchronizer plus one more for edge detect
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_d  <= 1'b1;
		end else begin
			rxd_s1 <= rxd_i;
			rxd_s2 <= rxd_s1;
			rxd_d  <= rxd_s2;
		end
	end

	assign fall = rxd_d && !rxd_s2;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= RX_IDLE;
			bit_cnt      <= 3'd0;
			byte_valid_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// start bit must still be low at mid-bit
					if (bit_mid) begin
						bit_cnt <= 3'd0;
						if (rxd_s2) begin
							state <= RX_IDLE;
						end else begin
							state <= RX_DATA;
						end
					end
				end
				RX_DATA: begin
					if (bit_mid) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					if (bit_mid) begin
						byte_valid_o <= rxd_s2;
						state        <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_mid) begin
			shift_q <= {rxd_s2, shift_q[7:1]};
		end
	end

	assign byte_o = shift_q;

endmodule : uart_rx_deserializer

//--- hdl/uart_tx_serializer.sv
`timescale 1ns/10ps

module uart_tx_serializer import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       empty_i,
	input  logic [7:0] byte_i,
	output logic       pop_o,
	input  logic       cts_i,
	output logic       busy_o,
	output logic       txd_o
);

	tx_state_e  state;
	logic       bit_end;
	logic       load_q;
	logic [2:0] bit_cnt;
	logic [7:0] shift_q;

	uart_baud_timer u_baud (
		.clk   (clk),
		.rst   (rst),
		.run_i (state != TX_IDLE),
		.mid_o (),
		.end_o (bit_end)
	);

	// cts only matters between frames
	assign pop_o  = (state == TX_IDLE) && !empty_i && !cts_i;
	assign busy_o = pop_o || (state != TX_IDLE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= TX_IDLE;
			load_q  <= 1'b0;
			bit_cnt <= 3'd0;
		end else begin
			load_q <= pop_o;
			case (state)
				TX_IDLE: begin
					if (pop_o) begin
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						bit_cnt <= 3'd0;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// fifo read data shows up one cycle after the pop
	always_ff @(posedge clk) begin
		if (load_q) begin
			shift_q <= byte_i;
		end else if (state == TX_DATA && bit_end) begin
			shift_q <= {1'b1, shift_q[7:1]};
		end
	end

	assign txd_o = (state == TX_START) ? 1'b0 :
	               (state == TX_DATA)  ? shift_q[0] : 1'b1;

endmodule : uart_tx_serializer

//--- sources.f
+incdir+hdl
+incdir+tests
hdl/uart_pkg.sv
hdl/simp_bus_if.sv
hdl/axil2simp.sv
hdl/byte_fifo.sv
hdl/uart_baud_timer.sv
hdl/uart_tx_serializer.sv
hdl/uart_rx_deserializer.sv
hdl/uart_regs.sv
hdl/uart_axil.sv
tests/tb_uart_axil.sv

//--- tests/uart_tb_tasks.svh
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("CHECKS FAILED");
	$fatal(1, "simulation stopped at first failure");
endtask

task automatic check_eq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		abort_run($sformatf("ERR %0t %s: got 0x%0h, expected 0x%0h",
			$time, name, actual, expected));
	end
endtask

task automatic axil_write(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
	int n;
	@(posedge clk);
	awvalid_i <= 1'b1;
	awaddr_i  <= addr;
	wvalid_i  <= 1'b1;
	wdata_i   <= data;
	wstrb_i   <= 4'hf;
	bready_i  <= 1'b1;
	n = 0;
	// handshake lands on the edge after ready is seen
	@(negedge clk);
	while (!(awready_o && wready_o)) begin
		n++;
		if (n > HS_LIMIT) begin
			abort_run("timeout: awready and wready never came");
		end
		@(negedge clk);
	end
	@(posedge clk);
	awvalid_i <= 1'b0;
	wvalid_i  <= 1'b0;
	n = 0;
	@(negedge clk);
	while (!bvalid_o) begin
		n++;
		if (n > HS_LIMIT) begin
			abort_run("timeout: no write response on bvalid");
		end
		@(negedge clk);
	end
	resp = bresp_o;
	@(posedge clk);
	bready_i <= 1'b0;
endtask

task automatic axil_read(input logic [`UART_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
	int n;
	@(posedge clk);
	arvalid_i <= 1'b1;
	araddr_i  <= addr;
	rready_i  <= 1'b1;
	n = 0;
	@(negedge clk);
	while (!arready_o) begin
		n++;
		if (n > HS_LIMIT) begin
			abort_run("timeout: arready never came");
		end
		@(negedge clk);
	end
	@(posedge clk);
	arvalid_i <= 1'b0;
	n = 0;
	@(negedge clk);
	while (!rvalid_o) begin
		n++;
		if (n > HS_LIMIT) begin
			abort_run("timeout: no read data on rvalid");
		end
		@(negedge clk);
	end
	data = rdata_o;
	resp = rresp_o;
	@(posedge clk);
	rready_i <= 1'b0;
endtask

task automatic write_expect(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
	logic [1:0] resp;
	axil_write(addr, data, resp);
	check_eq("bresp", resp, exp_resp);
endtask

task automatic read_expect(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp, input string name);
	logic [31:0] data;
	logic [1:0]  resp;
	axil_read(addr, data, resp);
	check_eq(name, data, exp_data);
	check_eq({name, " rresp"}, resp, exp_resp);
endtask

// start bit, 8 data bits lsb first, stop bit, then one idle bit
task automatic send_frame(input logic [7:0] data, input logic stop_bit);
	logic [9:0] bits;
	bits = {stop_bit, data, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge clk);
		uart_rx_i <= bits[i];
		repeat (CPB - 1) @(posedge clk);
	end
	@(posedge clk);
	uart_rx_i <= 1'b1;
	repeat (CPB - 1) @(posedge clk);
endtask

task automatic capture_frame(output logic [7:0] data, output logic stop_bit);
	int         n;
	logic [7:0] sr;
	n = 0;
	@(negedge clk);
	while (uart_tx_o !== 1'b0) begin
		n++;
		if (n > FRAME_LIMIT) begin
			abort_run("timeout: no start bit on uart_tx_o");
		end
		@(negedge clk);
	end
	// middle of the start bit
	repeat (CPB / 2 - 1) @(negedge clk);
	check_eq("uart_tx_o start bit", uart_tx_o, 1'b0);
	for (int i = 0; i < 8; i++) begin
		repeat (CPB) @(negedge clk);
		sr[i] = uart_tx_o;
	end
	repeat (CPB) @(negedge clk);
	stop_bit = uart_tx_o;
	data = sr;
endtask

`endif

//--- tests/tb_uart_axil.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module tb_uart_axil;

	localparam int         CPB         = `UART_CLKS_PER_BIT;
	localparam int         HS_LIMIT    = 50;
	localparam int         FRAME_LIMIT = 20 * CPB;
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                    clk;
	logic                    rst;
	logic                    awvalid_i;
	logic [`UART_ADDR_W-1:0] awaddr_i;
	logic                    awready_o;
	logic                    wvalid_i;
	logic [31:0]             wdata_i;
	logic [3:0]              wstrb_i;
	logic                    wready_o;
	logic                    bvalid_o;
	logic [1:0]              bresp_o;
	logic                    bready_i;
	logic                    arvalid_i;
	logic [`UART_ADDR_W-1:0] araddr_i;
	logic                    arready_o;
	logic                    rvalid_o;
	logic [31:0]             rdata_o;
	logic [1:0]              rresp_o;
	logic                    rready_i;
	logic                    uart_rx_i;
	logic                    uart_tx_o;
	logic                    uart_cts_i;
	logic                    uart_rts_o;

	// bytes parked in the tx fifo while cts is high
	logic [7:0]              held_bytes [16];

	uart_axil DUT (
		.clk        (clk),
		.rst        (rst),
		.awvalid_i  (awvalid_i),
		.awaddr_i   (awaddr_i),
		.awready_o  (awready_o),
		.wvalid_i   (wvalid_i),
		.wdata_i    (wdata_i),
		.wstrb_i    (wstrb_i),
		.wready_o   (wready_o),
		.bvalid_o   (bvalid_o),
		.bresp_o    (bresp_o),
		.bready_i   (bready_i),
		.arvalid_i  (arvalid_i),
		.araddr_i   (araddr_i),
		.arready_o  (arready_o),
		.rvalid_o   (rvalid_o),
		.rdata_o    (rdata_o),
		.rresp_o    (rresp_o),
		.rready_i   (rready_i),
		.uart_rx_i  (uart_rx_i),
		.uart_tx_o  (uart_tx_o),
		.uart_cts_i (uart_cts_i),
		.uart_rts_o (uart_rts_o)
	);

	`include "uart_tb_tasks.svh"

	task automatic reset_state();
		@(negedge clk);
		check_eq("uart_tx_o", uart_tx_o, 1'b1);
		check_eq("uart_rts_o", uart_rts_o, 1'b0);
		read_expect(`UART_RX_NUM_ADDR, 32'd0, RESP_OKAY, "rx count");
		// only rx empty set
		read_expect(`UART_STATUS_ADDR, 32'h0000_0002, RESP_OKAY, "status");
	endtask

	task automatic tx_order();
		logic [31:0] words [5];
		logic [7:0]  got;
		logic        stop;
		for (int i = 0; i < 5; i++) begin
			words[i] = $urandom;
		end
		// first frame starts while later writes are still going
		fork
			begin
				for (int i = 0; i < 5; i++) begin
					write_expect(`UART_DATA_ADDR, words[i], RESP_OKAY);
				end
				// serializer still working through the queued bytes
				read_expect(`UART_STATUS_ADDR, 32'h0000_0006, RESP_OKAY,
					"status while sending");
			end
			for (int j = 0; j < 5; j++) begin
				capture_frame(got, stop);
				check_eq("tx frame", got, words[j][7:0]);
				check_eq("tx stop bit", stop, 1'b1);
			end
		join
	endtask

	task automatic rx_path();
		logic [7:0] sent [6];
		for (int i = 0; i < 6; i++) begin
			sent[i] = 8'($urandom);
			send_frame(sent[i], 1'b1);
		end
		read_expect(`UART_RX_NUM_ADDR, 32'd6, RESP_OKAY, "rx count");
		for (int i = 0; i < 6; i++) begin
			read_expect(`UART_DATA_ADDR, {24'd0, sent[i]}, RESP_OKAY, "rx data");
		end
		read_expect(`UART_DATA_ADDR, 32'd0, RESP_OKAY, "rx data when empty");
	endtask

	task automatic error_responses();
		write_expect(4'd12, $urandom, RESP_SLVERR);
		read_expect(4'd12, 32'd0, RESP_SLVERR, "unmapped read");
		@(posedge clk);
		uart_cts_i <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			held_bytes[i] = 8'($urandom);
			write_expect(`UART_DATA_ADDR, {24'd0, held_bytes[i]}, RESP_OKAY);
		end
		write_expect(`UART_DATA_ADDR, 32'h0000_00a5, RESP_SLVERR);
		// tx full and rx empty while the serializer is held off
		read_expect(`UART_STATUS_ADDR, 32'h0000_0003, RESP_OKAY, "status");
	endtask

	task automatic flow_control();
		logic [7:0] got;
		logic       stop;
		logic [7:0] sent [17];
		for (int i = 0; i < 30 * CPB; i++) begin
			@(negedge clk);
			check_eq("uart_tx_o while cts high", uart_tx_o, 1'b1);
		end
		@(posedge clk);
		uart_cts_i <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			capture_frame(got, stop);
			check_eq("tx frame after cts", got, held_bytes[i]);
			check_eq("tx stop bit", stop, 1'b1);
		end
		for (int i = 0; i < 17; i++) begin
			sent[i] = 8'($urandom);
			send_frame(sent[i], 1'b1);
		end
		@(negedge clk);
		check_eq("uart_rts_o", uart_rts_o, 1'b1);
		read_expect(`UART_RX_NUM_ADDR, 32'd16, RESP_OKAY, "rx count");
		// the 17th byte is lost
		for (int i = 0; i < 16; i++) begin
			read_expect(`UART_DATA_ADDR, {24'd0, sent[i]}, RESP_OKAY, "rx data");
		end
		@(negedge clk);
		check_eq("uart_rts_o", uart_rts_o, 1'b0);
	endtask

	task automatic framing_error();
		logic [7:0] good;
		read_expect(`UART_RX_NUM_ADDR, 32'd0, RESP_OKAY, "rx count");
		send_frame(8'($urandom), 1'b0);
		read_expect(`UART_RX_NUM_ADDR, 32'd0, RESP_OKAY, "rx count after bad stop");
		good = 8'($urandom);
		send_frame(good, 1'b1);
		read_expect(`UART_RX_NUM_ADDR, 32'd1, RESP_OKAY, "rx count");
		read_expect(`UART_DATA_ADDR, {24'd0, good}, RESP_OKAY, "rx data");
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst        = 1'b1;
		awvalid_i  = 1'b0;
		awaddr_i   = '0;
		wvalid_i   = 1'b0;
		wdata_i    = 32'd0;
		wstrb_i    = 4'h0;
		bready_i   = 1'b0;
		arvalid_i  = 1'b0;
		araddr_i   = '0;
		rready_i   = 1'b0;
		uart_rx_i  = 1'b1;
		uart_cts_i = 1'b0;
		void'($urandom(32'ha5f2_a3a0));
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		tx_order();
		rx_path();
		error_responses();
		flow_control();
		framing_error();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule : tb_uart_axil
